//--- axi_wr_xbar.f
design/axi_pkg.sv
design/addr_map_pkg.sv
design/slave_cfg_regs.sv
design/aw_arbiter.sv
design/w_router.sv
design/b_router.sv
design/axi_wr_xbar.sv
verification/axi_wr_xbar_assert.sv
verification/axi_wr_xbar_tb.sv

//--- design/addr_map_pkg.sv
`default_nettype none

package addr_map_pkg;

    // Region lives in the top address bits
    localparam int REGION_W = 4;
    localparam int OFFSET_W = axi_pkg::ADDR_W - REGION_W;

    // Largest slave count the decode and config register support
    localparam int MAX_SLV = 8;

    // One AW address word, seen flat or as region plus offset
    typedef union packed {
        logic [axi_pkg::ADDR_W-1:0] flat;
        struct packed {
            logic [REGION_W-1:0] region;
            logic [OFFSET_W-1:0] offset;
        } fld;
    } aw_addr_u;

    // Enabled region below num_slv picks that slave, anything else the default (num_slv)
    function automatic logic [REGION_W-1:0] decode_tgt(
        input logic [REGION_W-1:0] region,
        input logic [MAX_SLV-1:0]  en_mask,
        input int unsigned         num_slv
    );
        logic [REGION_W-1:0] tgt;
        tgt = REGION_W'(num_slv);
        for (int i = 0; i < MAX_SLV; i++) begin
            if (i < num_slv && en_mask[i] && region == REGION_W'(i)) begin
                tgt = REGION_W'(i);
            end
        end
        return tgt;
    endfunction

endpackage

`default_nettype wire

//--- design/aw_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module aw_arbiter #(
    parameter int  NUM_SLV = 3,
    localparam int TGT_W   = $clog2(NUM_SLV + 1)
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire  [1:0][axi_pkg::ADDR_W-1:0]          m_awaddr_i,
    input  wire  [1:0][axi_pkg::LEN_W-1:0]           m_awlen_i,
    input  wire  [1:0]                               m_awvalid_i,
    output logic [1:0]                               m_awready_o,
    output logic [NUM_SLV-1:0][axi_pkg::ADDR_W-1:0]  s_awaddr_o,
    output logic [NUM_SLV-1:0][axi_pkg::LEN_W-1:0]   s_awlen_o,
    output logic [NUM_SLV-1:0]                       s_awvalid_o,
    input  wire  [NUM_SLV-1:0]                       s_awready_i,
    input  wire  [NUM_SLV-1:0]                       en_mask_i,
    input  wire                                      done_i,
    output logic                                     lock_o,
    output logic                                     own_o,
    output logic [TGT_W-1:0]                         tgt_o
);

    logic                             lock_q;
    logic                             own_q;
    logic [TGT_W-1:0]                 tgt_q;
    logic                             rr_q;
    logic                             gnt;
    logic                             gnt_vld;
    addr_map_pkg::aw_addr_u           addr_u;
    logic [addr_map_pkg::MAX_SLV-1:0] mask_ext;
    logic [TGT_W-1:0]                 tgt_d;
    logic [NUM_SLV:0]                 ready_ext;
    logic                             aw_hs;

    // rr_q has priority, the other master wins only when rr_q is idle
    always_comb begin
        gnt_vld = 1'b0;
        gnt     = rr_q;
        if (!lock_q) begin
            if (m_awvalid_i[rr_q]) begin
                gnt_vld = 1'b1;
            end else if (m_awvalid_i[~rr_q]) begin
                gnt_vld = 1'b1;
                gnt     = ~rr_q;
            end
        end
    end

    // Region decode of the granted address
    always_comb begin
        addr_u.flat           = m_awaddr_i[gnt];
        mask_ext              = '0;
        mask_ext[NUM_SLV-1:0] = en_mask_i;
        tgt_d = TGT_W'(addr_map_pkg::decode_tgt(addr_u.fld.region, mask_ext, NUM_SLV));
    end

    // Default slave accepts AW at once
    assign ready_ext = {1'b1, s_awready_i};
    assign aw_hs     = gnt_vld && ready_ext[tgt_d];

    always_comb begin
        for (int i = 0; i < NUM_SLV; i++) begin
            s_awaddr_o[i]  = m_awaddr_i[gnt];
            s_awlen_o[i]   = m_awlen_i[gnt];
            s_awvalid_o[i] = gnt_vld && (tgt_d == TGT_W'(i));
        end
    end

    always_comb begin
        m_awready_o      = '0;
        m_awready_o[gnt] = aw_hs;
    end

    // Route held from the AW handshake until the B handshake
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lock_q <= 1'b0;
            own_q  <= 1'b0;
            tgt_q  <= '0;
            rr_q   <= 1'b0;
        end else if (aw_hs) begin
            lock_q <= 1'b1;
            own_q  <= gnt;
            tgt_q  <= tgt_d;
            rr_q   <= ~gnt;
        end else if (done_i) begin
            lock_q <= 1'b0;
        end
    end

    assign lock_o = lock_q;
    assign own_o  = own_q;
    assign tgt_o  = tgt_q;

endmodule

`default_nettype wire

//--- design/axi_pkg.sv
`default_nettype none

package axi_pkg;

    // Channel field widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int LEN_W  = 8;
    localparam int RESP_W = 2;

    // Write response codes
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

//--- design/axi_wr_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_xbar #(
    parameter int NUM_SLV = 3
) (
    input  wire                                      clk,
    input  wire                                      rst,
    // Masters
    input  wire  [1:0][axi_pkg::ADDR_W-1:0]          m_awaddr_i,
    input  wire  [1:0][axi_pkg::LEN_W-1:0]           m_awlen_i,
    input  wire  [1:0]                               m_awvalid_i,
    output logic [1:0]                               m_awready_o,
    input  wire  [1:0][axi_pkg::DATA_W-1:0]          m_wdata_i,
    input  wire  [1:0][axi_pkg::STRB_W-1:0]          m_wstrb_i,
    input  wire  [1:0]                               m_wlast_i,
    input  wire  [1:0]                               m_wvalid_i,
    output logic [1:0]                               m_wready_o,
    output logic [1:0][axi_pkg::RESP_W-1:0]          m_bresp_o,
    output logic [1:0]                               m_bvalid_o,
    input  wire  [1:0]                               m_bready_i,
    // Slaves
    output logic [NUM_SLV-1:0][axi_pkg::ADDR_W-1:0]  s_awaddr_o,
    output logic [NUM_SLV-1:0][axi_pkg::LEN_W-1:0]   s_awlen_o,
    output logic [NUM_SLV-1:0]                       s_awvalid_o,
    input  wire  [NUM_SLV-1:0]                       s_awready_i,
    output logic [NUM_SLV-1:0][axi_pkg::DATA_W-1:0]  s_wdata_o,
    output logic [NUM_SLV-1:0][axi_pkg::STRB_W-1:0]  s_wstrb_o,
    output logic [NUM_SLV-1:0]                       s_wlast_o,
    output logic [NUM_SLV-1:0]                       s_wvalid_o,
    input  wire  [NUM_SLV-1:0]                       s_wready_i,
    input  wire  [NUM_SLV-1:0][axi_pkg::RESP_W-1:0]  s_bresp_i,
    input  wire  [NUM_SLV-1:0]                       s_bvalid_i,
    output logic [NUM_SLV-1:0]                       s_bready_o,
    // Config
    input  wire                                      cfg_we_i,
    input  wire  [addr_map_pkg::MAX_SLV-1:0]         cfg_wdata_i,
    output logic [addr_map_pkg::MAX_SLV-1:0]         cfg_rdata_o
);

    localparam int TGT_W = $clog2(NUM_SLV + 1);

    logic [NUM_SLV-1:0] en_mask;
    logic               lock;
    logic               own;
    logic [TGT_W-1:0]   tgt;
    logic               last_seen;
    logic               done;

    slave_cfg_regs #(
        .NUM_SLV     (NUM_SLV)
    ) u_slave_cfg_regs (
        .clk         (clk),
        .rst         (rst),
        .cfg_we_i    (cfg_we_i),
        .cfg_wdata_i (cfg_wdata_i),
        .en_mask_o   (en_mask),
        .cfg_rdata_o (cfg_rdata_o)
    );

    aw_arbiter #(
        .NUM_SLV     (NUM_SLV)
    ) u_aw_arbiter (
        .clk         (clk),
        .rst         (rst),
        .m_awaddr_i  (m_awaddr_i),
        .m_awlen_i   (m_awlen_i),
        .m_awvalid_i (m_awvalid_i),
        .m_awready_o (m_awready_o),
        .s_awaddr_o  (s_awaddr_o),
        .s_awlen_o   (s_awlen_o),
        .s_awvalid_o (s_awvalid_o),
        .s_awready_i (s_awready_i),
        .en_mask_i   (en_mask),
        .done_i      (done),
        .lock_o      (lock),
        .own_o       (own),
        .tgt_o       (tgt)
    );

    w_router #(
        .NUM_SLV     (NUM_SLV)
    ) u_w_router (
        .clk         (clk),
        .rst         (rst),
        .m_wdata_i   (m_wdata_i),
        .m_wstrb_i   (m_wstrb_i),
        .m_wlast_i   (m_wlast_i),
        .m_wvalid_i  (m_wvalid_i),
        .m_wready_o  (m_wready_o),
        .s_wdata_o   (s_wdata_o),
        .s_wstrb_o   (s_wstrb_o),
        .s_wlast_o   (s_wlast_o),
        .s_wvalid_o  (s_wvalid_o),
        .s_wready_i  (s_wready_i),
        .lock_i      (lock),
        .own_i       (own),
        .tgt_i       (tgt),
        .last_seen_o (last_seen)
    );

    b_router #(
        .NUM_SLV     (NUM_SLV)
    ) u_b_router (
        .clk         (clk),
        .rst         (rst),
        .s_bresp_i   (s_bresp_i),
        .s_bvalid_i  (s_bvalid_i),
        .s_bready_o  (s_bready_o),
        .m_bresp_o   (m_bresp_o),
        .m_bvalid_o  (m_bvalid_o),
        .m_bready_i  (m_bready_i),
        .lock_i      (lock),
        .own_i       (own),
        .tgt_i       (tgt),
        .last_seen_i (last_seen),
        .done_o      (done)
    );

endmodule

`default_nettype wire

//--- design/b_router.sv
`timescale 1ns/1ps
`default_nettype none

module b_router #(
    parameter int  NUM_SLV = 3,
    localparam int TGT_W   = $clog2(NUM_SLV + 1)
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire  [NUM_SLV-1:0][axi_pkg::RESP_W-1:0]  s_bresp_i,
    input  wire  [NUM_SLV-1:0]                       s_bvalid_i,
    output logic [NUM_SLV-1:0]                       s_bready_o,
    output logic [1:0][axi_pkg::RESP_W-1:0]          m_bresp_o,
    output logic [1:0]                               m_bvalid_o,
    input  wire  [1:0]                               m_bready_i,
    input  wire                                      lock_i,
    input  wire                                      own_i,
    input  wire  [TGT_W-1:0]                         tgt_i,
    input  wire                                      last_seen_i,
    output logic                                     done_o
);

    logic [NUM_SLV:0][axi_pkg::RESP_W-1:0] resp_ext;
    logic [NUM_SLV:0]                      valid_ext;
    logic                                  active;
    logic                                  bvalid_sel;
    logic                                  bready_sel;
    logic                                  b_hs;

    // Window between the last W beat and the B handshake of this write
    assign active = lock_i && last_seen_i;

    // Top entry is the default slave answering DECERR
    assign resp_ext   = {axi_pkg::RESP_DECERR, s_bresp_i};
    assign valid_ext  = {1'b1, s_bvalid_i};
    assign bvalid_sel = active && valid_ext[tgt_i];
    assign bready_sel = m_bready_i[own_i];
    assign b_hs       = bvalid_sel && bready_sel;

    for (genvar i = 0; i < NUM_SLV; i++) begin : g_slv
        assign s_bready_o[i] = active && bready_sel && (tgt_i == TGT_W'(i));
    end

    for (genvar m = 0; m < 2; m++) begin : g_mst
        assign m_bvalid_o[m] = bvalid_sel && (own_i == 1'(m));
        assign m_bresp_o[m]  = (own_i == 1'(m)) ? resp_ext[tgt_i] : axi_pkg::RESP_OKAY;
    end

    assign done_o = b_hs;

endmodule

`default_nettype wire

//--- design/slave_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module slave_cfg_regs #(
    parameter int NUM_SLV = 3
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               cfg_we_i,
    input  wire  [addr_map_pkg::MAX_SLV-1:0]  cfg_wdata_i,
    output logic [NUM_SLV-1:0]                en_mask_o,
    output logic [addr_map_pkg::MAX_SLV-1:0]  cfg_rdata_o
);

    logic [NUM_SLV-1:0] en_mask_q;

    // All slaves enabled out of reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            en_mask_q <= '1;
        end else if (cfg_we_i) begin
            en_mask_q <= cfg_wdata_i[NUM_SLV-1:0];
        end
    end

    assign en_mask_o = en_mask_q;

    // Bits above NUM_SLV read back as zero
    always_comb begin
        cfg_rdata_o              = '0;
        cfg_rdata_o[NUM_SLV-1:0] = en_mask_q;
    end

endmodule

`default_nettype wire

//--- design/w_router.sv
`timescale 1ns/1ps
`default_nettype none

module w_router #(
    parameter int  NUM_SLV = 3,
    localparam int TGT_W   = $clog2(NUM_SLV + 1)
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire  [1:0][axi_pkg::DATA_W-1:0]          m_wdata_i,
    input  wire  [1:0][axi_pkg::STRB_W-1:0]          m_wstrb_i,
    input  wire  [1:0]                               m_wlast_i,
    input  wire  [1:0]                               m_wvalid_i,
    output logic [1:0]                               m_wready_o,
    output logic [NUM_SLV-1:0][axi_pkg::DATA_W-1:0]  s_wdata_o,
    output logic [NUM_SLV-1:0][axi_pkg::STRB_W-1:0]  s_wstrb_o,
    output logic [NUM_SLV-1:0]                       s_wlast_o,
    output logic [NUM_SLV-1:0]                       s_wvalid_o,
    input  wire  [NUM_SLV-1:0]                       s_wready_i,
    input  wire                                      lock_i,
    input  wire                                      own_i,
    input  wire  [TGT_W-1:0]                         tgt_i,
    output logic                                     last_seen_o
);

    logic [axi_pkg::DATA_W-1:0] data_m;
    logic [axi_pkg::STRB_W-1:0] strb_m;
    logic                       last_m;
    logic                       valid_m;
    logic [NUM_SLV:0]           ready_ext;
    logic                       ready_s;
    logic                       beat_hs;
    logic                       last_seen_q;

    // Owner's beat
    assign data_m = m_wdata_i[own_i];
    assign strb_m = m_wstrb_i[own_i];
    assign last_m = m_wlast_i[own_i];

    // Nothing passes once the last beat of this burst went through
    assign valid_m = lock_i && !last_seen_q && m_wvalid_i[own_i];

    // Default slave sinks beats at once
    assign ready_ext = {1'b1, s_wready_i};
    assign ready_s   = ready_ext[tgt_i];
    assign beat_hs   = valid_m && ready_s;

    for (genvar i = 0; i < NUM_SLV; i++) begin : g_slv
        assign s_wvalid_o[i] = valid_m && (tgt_i == TGT_W'(i));
        assign s_wdata_o[i]  = data_m;
        assign s_wlast_o[i]  = last_m;
        // Idle slaves see full strobes
        assign s_wstrb_o[i]  = (valid_m && (tgt_i == TGT_W'(i))) ? strb_m : '1;
    end

    always_comb begin
        m_wready_o        = '0;
        m_wready_o[own_i] = beat_hs;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            last_seen_q <= 1'b0;
        end else if (!lock_i) begin
            last_seen_q <= 1'b0;
        end else if (beat_hs && last_m) begin
            last_seen_q <= 1'b1;
        end
    end

    assign last_seen_o = last_seen_q;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the write crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module axi_wr_xbar_tb \
    -f axi_wr_xbar.f \
    -o axi_wr_xbar_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/axi_wr_xbar_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

//--- verification/axi_wr_xbar_assert.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_xbar_assert #(
    parameter int NUM_SLV = 3
) (
    input wire               clk,
    input wire               rst,
    input wire [NUM_SLV-1:0] s_valid_i,
    input wire [NUM_SLV-1:0] s_ready_i,
    input wire               done_i,
    input wire [1:0]         m_ready_i,
    input wire               chk_grant_i
);

    logic busy_q;

    // Write in flight from the AW handshake until done
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy_q <= 1'b0;
        end else if (|m_ready_i) begin
            busy_q <= 1'b1;
        end else if (done_i) begin
            busy_q <= 1'b0;
        end
    end

    // A stalled slave keeps seeing valid
    for (genvar i = 0; i < NUM_SLV; i++) begin : g_hold
        a_valid_hold: assert property (@(posedge clk) disable iff (!rst)
            (s_valid_i[i] && !s_ready_i[i]) |=> s_valid_i[i])
            else $error("Valid to slave %0d dropped before ready", i);
    end

    a_one_slave: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(s_valid_i))
        else $error("More than one slave valid at once");

    // No AW ready toward a master while a write is in flight
    a_no_grant_locked: assert property (@(posedge clk) disable iff (!rst)
        (chk_grant_i && busy_q) |-> (m_ready_i == 2'b00))
        else $error("AW granted while the route is locked");

endmodule

bind aw_arbiter axi_wr_xbar_assert #(.NUM_SLV(NUM_SLV)) u_aw_assert (
    .clk         (clk),
    .rst         (rst),
    .s_valid_i   (s_awvalid_o),
    .s_ready_i   (s_awready_i),
    .done_i      (done_i),
    .m_ready_i   (m_awready_o),
    .chk_grant_i (1'b1)
);

bind w_router axi_wr_xbar_assert #(.NUM_SLV(NUM_SLV)) u_w_assert (
    .clk         (clk),
    .rst         (rst),
    .s_valid_i   (s_wvalid_o),
    .s_ready_i   (s_wready_i),
    .done_i      (1'b0),
    .m_ready_i   (m_wready_o),
    .chk_grant_i (1'b0)
);

`default_nettype wire

//--- verification/axi_wr_xbar_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_xbar_tb;

    localparam int NUM_SLV  = 3;
    localparam int NUM_ROWS = 7;
    localparam logic [7:0] SLV_MASK = 8'((1 << NUM_SLV) - 1);

    typedef struct {
        bit         req0;
        bit         req1;
        logic [31:0] addr0;
        logic [31:0] addr1;
        logic [7:0] len0;
        logic [7:0] len1;
        logic [7:0] cfg;
        int         own;
        int         tgt;
        logic [1:0] resp;
    } row_t;

    logic clk;
    logic rst;
    logic [1:0][31:0]           m_awaddr_i;
    logic [1:0][7:0]            m_awlen_i;
    logic [1:0]                 m_awvalid_i;
    logic [1:0]                 m_awready_o;
    logic [1:0][31:0]           m_wdata_i;
    logic [1:0][3:0]            m_wstrb_i;
    logic [1:0]                 m_wlast_i;
    logic [1:0]                 m_wvalid_i;
    logic [1:0]                 m_wready_o;
    logic [1:0][1:0]            m_bresp_o;
    logic [1:0]                 m_bvalid_o;
    logic [1:0]                 m_bready_i;
    logic [NUM_SLV-1:0][31:0]   s_awaddr_o;
    logic [NUM_SLV-1:0][7:0]    s_awlen_o;
    logic [NUM_SLV-1:0]         s_awvalid_o;
    logic [NUM_SLV-1:0]         s_awready_i;
    logic [NUM_SLV-1:0][31:0]   s_wdata_o;
    logic [NUM_SLV-1:0][3:0]    s_wstrb_o;
    logic [NUM_SLV-1:0]         s_wlast_o;
    logic [NUM_SLV-1:0]         s_wvalid_o;
    logic [NUM_SLV-1:0]         s_wready_i;
    logic [NUM_SLV-1:0][1:0]    s_bresp_i;
    logic [NUM_SLV-1:0]         s_bvalid_i;
    logic [NUM_SLV-1:0]         s_bready_o;
    logic                       cfg_we_i;
    logic [7:0]                 cfg_wdata_i;
    logic [7:0]                 cfg_rdata_o;

    row_t        rows [NUM_ROWS];
    logic [31:0] rng_state = 32'h7b08_b632;
    int          cycles = 0;
    int          cycle_limit = 0;

    axi_wr_xbar #(
        .NUM_SLV (NUM_SLV)
    ) u_axi_wr_xbar (
        .clk(clk), .rst(rst),
        .m_awaddr_i(m_awaddr_i), .m_awlen_i(m_awlen_i),
        .m_awvalid_i(m_awvalid_i), .m_awready_o(m_awready_o),
        .m_wdata_i(m_wdata_i), .m_wstrb_i(m_wstrb_i), .m_wlast_i(m_wlast_i),
        .m_wvalid_i(m_wvalid_i), .m_wready_o(m_wready_o),
        .m_bresp_o(m_bresp_o), .m_bvalid_o(m_bvalid_o), .m_bready_i(m_bready_i),
        .s_awaddr_o(s_awaddr_o), .s_awlen_o(s_awlen_o),
        .s_awvalid_o(s_awvalid_o), .s_awready_i(s_awready_i),
        .s_wdata_o(s_wdata_o), .s_wstrb_o(s_wstrb_o), .s_wlast_o(s_wlast_o),
        .s_wvalid_o(s_wvalid_o), .s_wready_i(s_wready_i),
        .s_bresp_i(s_bresp_i), .s_bvalid_i(s_bvalid_i), .s_bready_o(s_bready_o),
        .cfg_we_i(cfg_we_i), .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Ready high about three cycles in four
    function automatic logic [NUM_SLV-1:0] ready_bits();
        logic [31:0]        r;
        logic [NUM_SLV-1:0] b;
        r = next_rand();
        for (int i = 0; i < NUM_SLV; i++) begin
            b[i] = (r[2*i +: 2] != 2'b00);
        end
        return b;
    endfunction

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got_v);
        assert (got_v === exp_v) else begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp_v, got_v);
            stop_run();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: no final B response within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    task automatic run_row(input int r);
        int          own;
        int          oth;
        int          tgt;
        int          len;
        int          beat;
        int          rcvd;
        bit          done_flag;
        logic [31:0] exp_sel;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        own = rows[r].own;
        oth = 1 - own;
        tgt = rows[r].tgt;
        len = (own == 0) ? int'(rows[r].len0) : int'(rows[r].len1);
        exp_sel = (tgt < NUM_SLV) ? (32'd1 << tgt) : 32'd0;

        // Config write and readback
        @(negedge clk);
        cfg_we_i    = 1'b1;
        cfg_wdata_i = rows[r].cfg;
        @(negedge clk);
        cfg_we_i = 1'b0;
        #1;
        check_val("cfg_rdata_o", {24'd0, rows[r].cfg & SLV_MASK}, {24'd0, cfg_rdata_o});
        @(negedge clk);

        m_awvalid_i   = {rows[r].req1, rows[r].req0};
        m_awaddr_i[0] = rows[r].addr0;
        m_awaddr_i[1] = rows[r].addr1;
        m_awlen_i[0]  = rows[r].len0;
        m_awlen_i[1]  = rows[r].len1;
        done_flag = 1'b0;
        while (!done_flag) begin
            s_awready_i = ready_bits();
            #1;
            check_val("m_awready_o other", 0, {31'd0, m_awready_o[oth]});
            check_val("s_awvalid_o", exp_sel, {29'd0, s_awvalid_o});
            check_val("m_awready_o", {31'd0, (tgt == NUM_SLV) || s_awready_i[tgt]},
                      {31'd0, m_awready_o[own]});
            if (tgt < NUM_SLV) begin
                check_val("s_awaddr_o", m_awaddr_i[own], s_awaddr_o[tgt]);
                check_val("s_awlen_o", {24'd0, m_awlen_i[own]}, {24'd0, s_awlen_o[tgt]});
            end
            done_flag = m_awready_o[own];
            @(negedge clk);
        end
        m_awvalid_i[own] = 1'b0;
        // All slaves take AW, so a grant to the waiting master would complete
        s_awready_i      = '1;

        beat  = 0;
        rcvd  = 0;
        wdata = next_rand();
        wstrb = next_rand() >> 28;
        while (beat <= len) begin
            m_wvalid_i[own] = 1'b1;
            m_wdata_i[own]  = wdata;
            m_wstrb_i[own]  = wstrb;
            m_wlast_i[own]  = (beat == len);
            s_wready_i      = ready_bits();
            #1;
            check_val("m_awready_o other", 0, {31'd0, m_awready_o[oth]});
            check_val("m_wready_o other", 0, {31'd0, m_wready_o[oth]});
            check_val("s_wvalid_o", exp_sel, {29'd0, s_wvalid_o});
            check_val("m_wready_o", {31'd0, (tgt == NUM_SLV) || s_wready_i[tgt]},
                      {31'd0, m_wready_o[own]});
            // Slave model records the beat
            if (tgt < NUM_SLV && s_wvalid_o[tgt] && s_wready_i[tgt]) begin
                check_val("s_wdata_o", wdata, s_wdata_o[tgt]);
                check_val("s_wstrb_o", {28'd0, wstrb}, {28'd0, s_wstrb_o[tgt]});
                check_val("s_wlast_o", {31'd0, beat == len}, {31'd0, s_wlast_o[tgt]});
                rcvd++;
            end
            if (m_wready_o[own]) begin
                beat++;
                wdata = next_rand();
                wstrb = next_rand() >> 28;
            end
            @(negedge clk);
        end
        m_wvalid_i = '0;
        m_wlast_i  = '0;
        s_wready_i = '0;
        if (tgt < NUM_SLV) begin
            check_val("received beats", len + 1, rcvd);
        end

        done_flag = 1'b0;
        while (!done_flag) begin
            m_bready_i[own] = (next_rand() % 4) != 0;
            if (tgt < NUM_SLV) begin
                s_bvalid_i[tgt] = 1'b1;
                s_bresp_i[tgt]  = axi_pkg::RESP_OKAY;
            end
            #1;
            check_val("m_awready_o other", 0, {31'd0, m_awready_o[oth]});
            check_val("m_bvalid_o other", 0, {31'd0, m_bvalid_o[oth]});
            check_val("m_bvalid_o", 1, {31'd0, m_bvalid_o[own]});
            check_val("s_bready_o", m_bready_i[own] ? exp_sel : 32'd0, {29'd0, s_bready_o});
            if (m_bready_i[own]) begin
                check_val("m_bresp_o", {30'd0, rows[r].resp}, {30'd0, m_bresp_o[own]});
                done_flag = 1'b1;
            end
            @(negedge clk);
        end
        s_bvalid_i  = '0;
        m_bready_i  = '0;
        m_awvalid_i = '0;
        s_awready_i = '0;
    endtask

    initial begin
        rst = 1'b0;
        m_awaddr_i = '0;
        m_awlen_i = '0;
        m_awvalid_i = '0;
        m_wdata_i = '0;
        m_wstrb_i = '0;
        m_wlast_i = '0;
        m_wvalid_i = '0;
        m_bready_i = '0;
        s_awready_i = '0;
        s_wready_i = '0;
        s_bresp_i = '0;
        s_bvalid_i = '0;
        cfg_we_i = 1'b0;
        cfg_wdata_i = '0;

        // req0 req1 addr0 addr1 len0 len1 cfg own tgt resp
        rows[0] = '{1, 1, 32'h0000_0040, 32'h1000_0080, 8'd3, 8'd1, 8'hFF, 0, 0,
                    axi_pkg::RESP_OKAY};
        rows[1] = '{1, 1, 32'h0000_0100, 32'h2000_0010, 8'd2, 8'd4, 8'hFF, 1, 2,
                    axi_pkg::RESP_OKAY};
        rows[2] = '{0, 1, 32'h0000_0000, 32'h1000_0300, 8'd0, 8'd0, 8'hFF, 1, 1,
                    axi_pkg::RESP_OKAY};
        // Region 5 is unmapped
        rows[3] = '{1, 1, 32'h5000_0000, 32'h2000_0000, 8'd2, 8'd1, 8'hFF, 0, 3,
                    axi_pkg::RESP_DECERR};
        // Slave 1 disabled
        rows[4] = '{1, 0, 32'h1000_0020, 32'h0000_0000, 8'd1, 8'd0, 8'hFD, 0, 3,
                    axi_pkg::RESP_DECERR};
        rows[5] = '{1, 1, 32'h0000_0000, 32'h1000_0400, 8'd0, 8'd3, 8'hFF, 1, 1,
                    axi_pkg::RESP_OKAY};
        rows[6] = '{1, 0, 32'h2000_0500, 32'h0000_0000, 8'd7, 8'd0, 8'hFF, 0, 2,
                    axi_pkg::RESP_OKAY};

        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += (int'(rows[r].own == 0 ? rows[r].len0 : rows[r].len1) + 1) * 4 + 20;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
